/* hw/cu_setup_pkg.sv */
package cu_setup_pkg;

// --------------------
// Widths
// --------------------
localparam int ADDR_W  = 32;
localparam int SETUP_W = 32;
localparam int COUNT_W = 16;

// Cache line geometry, entry index to byte address
localparam int LINE_BYTES = 64;
localparam int ADDR_SHIFT = 6;

// --------------------
// Request FIFO sizing
// --------------------
localparam int FIFO_DEPTH  = 32;
localparam int FIFO_PTR_W  = 5;
localparam int PROG_THRESH = 16;

// --------------------
// Setup word layout
// --------------------
localparam int FLUSH_EN_BIT = 2;
localparam int PROG_LSB     = 3;
localparam int PROG_MSB     = 15;
localparam int FLUSH_LSB    = 16;
localparam int FLUSH_MSB    = 31;

// --------------------
// Types
// --------------------
typedef struct packed {
    logic               valid;
    logic [SETUP_W-1:0] setup_word;
} setup_descriptor_t;

// Engine run configuration, start is a one-cycle strobe
typedef struct packed {
    logic               start;
    logic [COUNT_W-1:0] count;
    logic               flush_mode;
} read_config_t;

typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              flush_mode;
} mem_request_payload_t;

typedef struct packed {
    logic                 valid;
    mem_request_payload_t payload;
} mem_request_t;

// Program phase first, optional flush phase second
typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_PROG_START,
    SEQ_PROG_BUSY,
    SEQ_PROG_DONE,
    SEQ_FLUSH_START,
    SEQ_FLUSH_BUSY,
    SEQ_DONE
} sequencer_state_t;

endpackage

/* hw/cu_setup_top.sv */
`timescale 1ns/1ps

module cu_setup_top (
    input  logic                            ap_clk,
    input  logic                            areset_cu_setup,
    input  cu_setup_pkg::setup_descriptor_t descriptor,
    input  logic                            cu_flush,
    input  logic                            response_valid,
    output cu_setup_pkg::mem_request_t      request,
    input  logic                            request_ready,
    output logic                            done_out
);

// --------------------
// Internal wiring
// --------------------
cu_setup_pkg::read_config_t engine_config;
cu_setup_pkg::mem_request_t push_request;

logic engine_busy;
logic fifo_empty;
logic fifo_prog_full;

// --------------------
// Phase sequencer
// --------------------
setup_sequencer inst_setup_sequencer (
    .ap_clk          (ap_clk),
    .areset_cu_setup (areset_cu_setup),
    .descriptor      (descriptor),
    .cu_flush        (cu_flush),
    .response_valid  (response_valid),
    .engine_busy     (engine_busy),
    .fifo_empty      (fifo_empty),
    .engine_config   (engine_config),
    .done_out        (done_out)
);

// --------------------
// Read request generator
// --------------------
serial_read_engine inst_serial_read_engine (
    .ap_clk          (ap_clk),
    .areset_cu_setup (areset_cu_setup),
    .engine_config   (engine_config),
    .fifo_prog_full  (fifo_prog_full),
    .push_request    (push_request),
    .engine_busy     (engine_busy)
);

// --------------------
// Outgoing request FIFO
// --------------------
// Pop side faces the memory port directly
request_fifo inst_request_fifo (
    .ap_clk          (ap_clk),
    .areset_cu_setup (areset_cu_setup),
    .push_request    (push_request),
    .request         (request),
    .request_ready   (request_ready),
    .fifo_empty      (fifo_empty),
    .fifo_prog_full  (fifo_prog_full)
);

endmodule : cu_setup_top

/* hw/request_fifo.sv */
`timescale 1ns/1ps

module request_fifo (
    input  logic                       ap_clk,
    input  logic                       areset_cu_setup,
    input  cu_setup_pkg::mem_request_t push_request,
    output cu_setup_pkg::mem_request_t request,
    input  logic                       request_ready,
    output logic                       fifo_empty,
    output logic                       fifo_prog_full
);

// --------------------
// Storage and pointers
// --------------------
cu_setup_pkg::mem_request_payload_t mem [cu_setup_pkg::FIFO_DEPTH];

logic [cu_setup_pkg::FIFO_PTR_W-1:0] wr_ptr;
logic [cu_setup_pkg::FIFO_PTR_W-1:0] rd_ptr;
logic [cu_setup_pkg::FIFO_PTR_W:0]   occupancy;

logic fifo_full;
logic push_en;
logic pop_en;

assign fifo_empty     = (occupancy == '0);
assign fifo_full      = (occupancy == cu_setup_pkg::FIFO_DEPTH);
assign fifo_prog_full = (occupancy >= cu_setup_pkg::PROG_THRESH);

assign push_en = push_request.valid && !fifo_full;
assign pop_en  = request.valid && request_ready;

// Head entry shows on the output without a read strobe
assign request.valid   = !fifo_empty;
assign request.payload = mem[rd_ptr];

always_ff @(posedge ap_clk) begin
    if (push_en) begin
        mem[wr_ptr] <= push_request.payload;
    end
end

// --------------------
// Pointer update
// --------------------
always_ff @(posedge ap_clk) begin
    if (areset_cu_setup) begin
        wr_ptr    <= '0;
        rd_ptr    <= '0;
        occupancy <= '0;
    end else begin
        if (push_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        // Simultaneous push and pop leaves the level unchanged
        case ({push_en, pop_en})
            2'b10:   occupancy <= occupancy + 1'b1;
            2'b01:   occupancy <= occupancy - 1'b1;
            default: occupancy <= occupancy;
        endcase
    end
end

endmodule : request_fifo

/* hw/serial_read_engine.sv */
`timescale 1ns/1ps

module serial_read_engine (
    input  logic                       ap_clk,
    input  logic                       areset_cu_setup,
    input  cu_setup_pkg::read_config_t engine_config,
    input  logic                       fifo_prog_full,
    output cu_setup_pkg::mem_request_t push_request,
    output logic                       engine_busy
);

// --------------------
// Run state
// --------------------
logic [cu_setup_pkg::COUNT_W-1:0] entry_count;
logic [cu_setup_pkg::COUNT_W-1:0] entry_index;
logic                             run_flush_mode;

logic                             issue;
logic [cu_setup_pkg::ADDR_W-1:0]  entry_addr;

// One request per cycle, held off while the FIFO is nearly full
assign issue = engine_busy && (entry_index < entry_count) && !fifo_prog_full;

// Entry index to cache line byte address
assign entry_addr = {{(cu_setup_pkg::ADDR_W - cu_setup_pkg::COUNT_W){1'b0}}, entry_index}
                    << cu_setup_pkg::ADDR_SHIFT;

// Latched run parameters
always_ff @(posedge ap_clk) begin
    if (engine_config.start) begin
        entry_count    <= engine_config.count;
        run_flush_mode <= engine_config.flush_mode;
    end
end

// --------------------
// Busy and entry index
// --------------------
always_ff @(posedge ap_clk) begin
    if (areset_cu_setup) begin
        engine_busy <= 1'b0;
        entry_index <= '0;
    end else if (engine_config.start) begin
        engine_busy <= 1'b1;
        entry_index <= '0;
    end else begin
        if (issue) begin
            entry_index <= entry_index + 1'b1;
        end
        // All entries issued, the last push is on the bus this cycle
        if (engine_busy && (entry_index == entry_count)) begin
            engine_busy <= 1'b0;
        end
    end
end

// --------------------
// Push to request FIFO
// --------------------
always_ff @(posedge ap_clk) begin
    if (areset_cu_setup) begin
        push_request.valid <= 1'b0;
    end else begin
        push_request.valid <= issue;
    end
end

// Payload is only meaningful with valid
always_ff @(posedge ap_clk) begin
    if (issue) begin
        push_request.payload.addr       <= entry_addr;
        push_request.payload.flush_mode <= run_flush_mode;
    end
end

endmodule : serial_read_engine

/* hw/setup_sequencer.sv */
`timescale 1ns/1ps

module setup_sequencer (
    input  logic                            ap_clk,
    input  logic                            areset_cu_setup,
    input  cu_setup_pkg::setup_descriptor_t descriptor,
    input  logic                            cu_flush,
    input  logic                            response_valid,
    input  logic                            engine_busy,
    input  logic                            fifo_empty,
    output cu_setup_pkg::read_config_t      engine_config,
    output logic                            done_out
);

// --------------------
// Registered inputs
// --------------------
logic                               desc_valid_reg;
logic [cu_setup_pkg::SETUP_W-1:0]   setup_word_reg;
logic                               cu_flush_reg;

// Decoded setup fields
logic                               flush_enable;
logic [cu_setup_pkg::COUNT_W-1:0]   prog_count;
logic [cu_setup_pkg::COUNT_W-1:0]   flush_count;

cu_setup_pkg::sequencer_state_t     current_state;
cu_setup_pkg::sequencer_state_t     next_state;

logic [cu_setup_pkg::COUNT_W-1:0]   resp_count;
logic                               phase_clear;
logic                               in_flush;

// Descriptor only accepted while idle
always_ff @(posedge ap_clk) begin
    if (areset_cu_setup) begin
        desc_valid_reg <= 1'b0;
        cu_flush_reg   <= 1'b0;
    end else begin
        desc_valid_reg <= descriptor.valid && (current_state == cu_setup_pkg::SEQ_IDLE);
        cu_flush_reg   <= cu_flush;
    end
end

always_ff @(posedge ap_clk) begin
    if (descriptor.valid && (current_state == cu_setup_pkg::SEQ_IDLE)) begin
        setup_word_reg <= descriptor.setup_word;
    end
end

// --------------------
// Setup word decode
// --------------------
assign flush_enable = setup_word_reg[cu_setup_pkg::FLUSH_EN_BIT];
assign prog_count   = {{(cu_setup_pkg::COUNT_W - cu_setup_pkg::PROG_MSB
                         + cu_setup_pkg::PROG_LSB - 1){1'b0}},
                       setup_word_reg[cu_setup_pkg::PROG_MSB:cu_setup_pkg::PROG_LSB]};
assign flush_count  = setup_word_reg[cu_setup_pkg::FLUSH_MSB:cu_setup_pkg::FLUSH_LSB];

// Engine idle, FIFO drained and every response back
assign phase_clear = !engine_busy && fifo_empty && (resp_count == '0);

// --------------------
// Phase FSM
// --------------------
always_ff @(posedge ap_clk) begin
    if (areset_cu_setup) begin
        current_state <= cu_setup_pkg::SEQ_IDLE;
    end else begin
        current_state <= next_state;
    end
end

always_comb begin
    next_state = current_state;
    case (current_state)
        cu_setup_pkg::SEQ_IDLE: begin
            if (desc_valid_reg) begin
                next_state = cu_setup_pkg::SEQ_PROG_START;
            end
        end
        cu_setup_pkg::SEQ_PROG_START: begin
            next_state = cu_setup_pkg::SEQ_PROG_BUSY;
        end
        cu_setup_pkg::SEQ_PROG_BUSY: begin
            if (phase_clear) begin
                next_state = cu_setup_pkg::SEQ_PROG_DONE;
            end
        end
        cu_setup_pkg::SEQ_PROG_DONE: begin
            // Flush run waits on the external request
            if (!flush_enable) begin
                next_state = cu_setup_pkg::SEQ_DONE;
            end else if (cu_flush_reg) begin
                next_state = cu_setup_pkg::SEQ_FLUSH_START;
            end
        end
        cu_setup_pkg::SEQ_FLUSH_START: begin
            next_state = cu_setup_pkg::SEQ_FLUSH_BUSY;
        end
        cu_setup_pkg::SEQ_FLUSH_BUSY: begin
            if (phase_clear) begin
                next_state = cu_setup_pkg::SEQ_DONE;
            end
        end
        cu_setup_pkg::SEQ_DONE: begin
            next_state = cu_setup_pkg::SEQ_DONE;
        end
        default: begin
            next_state = cu_setup_pkg::SEQ_IDLE;
        end
    endcase
end

// --------------------
// Response counter
// --------------------
always_ff @(posedge ap_clk) begin
    if (areset_cu_setup) begin
        resp_count <= '0;
    end else if (current_state == cu_setup_pkg::SEQ_PROG_START) begin
        resp_count <= prog_count;
    end else if (current_state == cu_setup_pkg::SEQ_FLUSH_START) begin
        resp_count <= flush_count;
    end else if (response_valid && (resp_count != '0)) begin
        resp_count <= resp_count - 1'b1;
    end
end

// Done tracks SEQ_DONE on the same cycles
always_ff @(posedge ap_clk) begin
    if (areset_cu_setup) begin
        done_out <= 1'b0;
    end else begin
        done_out <= (next_state == cu_setup_pkg::SEQ_DONE);
    end
end

// --------------------
// Engine configuration
// --------------------
assign in_flush = (current_state == cu_setup_pkg::SEQ_FLUSH_START) ||
                  (current_state == cu_setup_pkg::SEQ_FLUSH_BUSY);

assign engine_config.start      = (current_state == cu_setup_pkg::SEQ_PROG_START) ||
                                  (current_state == cu_setup_pkg::SEQ_FLUSH_START);
assign engine_config.count      = in_flush ? flush_count : prog_count;
assign engine_config.flush_mode = in_flush;

endmodule : setup_sequencer

/* run_sim.sh */
#!/bin/sh
# Build the cu_setup testbench with Verilator and run it into a log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_cu_setup
LOG=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f \
    --top-module tb_cu_setup -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* testbench/cu_setup_model.svh */
// --------------------
// Scoreboard
// --------------------
// Requests still owed at the memory port, oldest first
cu_setup_pkg::mem_request_payload_t expected_q[$];

function automatic logic [cu_setup_pkg::SETUP_W-1:0] make_setup_word(
    input logic flush_en,
    input int   prog_cnt,
    input int   flush_cnt
);
    logic [cu_setup_pkg::SETUP_W-1:0] word;
    word = '0;
    word[cu_setup_pkg::FLUSH_EN_BIT] = flush_en;
    word[cu_setup_pkg::PROG_MSB:cu_setup_pkg::PROG_LSB] =
        prog_cnt[cu_setup_pkg::PROG_MSB-cu_setup_pkg::PROG_LSB:0];
    word[cu_setup_pkg::FLUSH_MSB:cu_setup_pkg::FLUSH_LSB] =
        flush_cnt[cu_setup_pkg::FLUSH_MSB-cu_setup_pkg::FLUSH_LSB:0];
    return word;
endfunction

// One run walks entries 0 to count-1, one cache line apart
task automatic expect_run(input int count, input logic flush_mode);
    cu_setup_pkg::mem_request_payload_t entry;
    for (int i = 0; i < count; i++) begin
        entry.addr       = i * cu_setup_pkg::LINE_BYTES;
        entry.flush_mode = flush_mode;
        expected_q.push_back(entry);
    end
endtask

// Program run, then the flush run when enabled
task automatic expect_setup(input logic [cu_setup_pkg::SETUP_W-1:0] word, output int total);
    int prog_cnt;
    int flush_cnt;
    prog_cnt  = int'(word[cu_setup_pkg::PROG_MSB:cu_setup_pkg::PROG_LSB]);
    flush_cnt = int'(word[cu_setup_pkg::FLUSH_MSB:cu_setup_pkg::FLUSH_LSB]);
    expect_run(prog_cnt, 1'b0);
    total = prog_cnt;
    if (word[cu_setup_pkg::FLUSH_EN_BIT]) begin
        expect_run(flush_cnt, 1'b1);
        total = total + flush_cnt;
    end
endtask

task automatic check_transfer(input cu_setup_pkg::mem_request_payload_t got);
    cu_setup_pkg::mem_request_payload_t exp;
    if (expected_q.size() == 0) begin
        $display("Unexpected request with address 0x%h at time %0t", got.addr, $time);
        error_count++;
    end else begin
        exp = expected_q.pop_front();
        if (got.addr != exp.addr) begin
            $display("Mismatch at %0t: addr 0x%h, expected 0x%h", $time, got.addr, exp.addr);
            error_count++;
        end
        if (got.flush_mode != exp.flush_mode) begin
            $display("Mismatch at %0t: flush_mode %0b, expected %0b",
                     $time, got.flush_mode, exp.flush_mode);
            error_count++;
        end
    end
endtask

/* testbench/tb_cu_setup.sv */
`timescale 1ns/1ps

module tb_cu_setup;

logic                            ap_clk;
logic                            areset_cu_setup;
cu_setup_pkg::setup_descriptor_t descriptor;
logic                            cu_flush;
logic                            response_valid;
cu_setup_pkg::mem_request_t      request;
logic                            request_ready;
logic                            done_out;

int error_count;
int accepted_count;
int responses_sent;
int expected_total;
int tests_passed;
int tests_failed;
bit random_ready;
bit withhold_last;

`include "cu_setup_model.svh"

cu_setup_top dut0 (
    .ap_clk          (ap_clk),
    .areset_cu_setup (areset_cu_setup),
    .descriptor      (descriptor),
    .cu_flush        (cu_flush),
    .response_valid  (response_valid),
    .request         (request),
    .request_ready   (request_ready),
    .done_out        (done_out)
);

initial begin
    ap_clk = 1'b0;
    forever #4 ap_clk = ~ap_clk;
end

// --------------------
// Memory side
// --------------------
// Each accepted request is scored and owes one response
always @(posedge ap_clk) begin
    if (!areset_cu_setup && request.valid && request_ready) begin
        if (request.payload.flush_mode && !cu_flush) begin
            $display("Flush request seen at time %0t before cu_flush was raised", $time);
            error_count++;
        end
        check_transfer(request.payload);
        accepted_count++;
    end
end

always @(negedge ap_clk) begin
    if (random_ready) begin
        request_ready = ($urandom_range(99) < 30);
    end else begin
        request_ready = 1'b1;
    end
end

task automatic hold_last_response();
    repeat (50) begin
        @(negedge ap_clk);
        if (done_out) begin
            $display("Mismatch at %0t: done_out high with a response withheld", $time);
            error_count++;
        end
    end
endtask

initial begin : responder
    int gap;
    forever begin
        @(negedge ap_clk);
        response_valid = 1'b0;
        if (responses_sent < accepted_count) begin
            gap = $urandom_range(3);
            repeat (gap) @(negedge ap_clk);
            if (withhold_last && (responses_sent == expected_total - 1)) begin
                hold_last_response();
            end
            response_valid = 1'b1;
            responses_sent++;
        end
    end
end

// --------------------
// Test steps
// --------------------
task automatic apply_reset();
    @(negedge ap_clk);
    areset_cu_setup = 1'b1;
    descriptor      = '0;
    cu_flush        = 1'b0;
    accepted_count  = 0;
    responses_sent  = 0;
    expected_q.delete();
    repeat (4) @(negedge ap_clk);
    areset_cu_setup = 1'b0;
endtask

task automatic send_descriptor(input logic [cu_setup_pkg::SETUP_W-1:0] word);
    int total;
    expect_setup(word, total);
    expected_total = total;
    @(negedge ap_clk);
    descriptor.valid      = 1'b1;
    descriptor.setup_word = word;
    @(negedge ap_clk);
    descriptor.valid = 1'b0;
endtask

task automatic wait_for_done(input int limit);
    int cycles;
    cycles = 0;
    while (!done_out && (cycles < limit)) begin
        @(negedge ap_clk);
        cycles++;
    end
    if (!done_out) begin
        $display("Timed out after %0d cycles waiting for done_out", limit);
        error_count++;
    end
endtask

task automatic wait_for_responses(input int target, input int limit);
    int cycles;
    cycles = 0;
    while ((responses_sent < target) && (cycles < limit)) begin
        @(negedge ap_clk);
        cycles++;
    end
    if (responses_sent < target) begin
        $display("Timed out after %0d cycles waiting for %0d responses", limit, target);
        error_count++;
    end
endtask

// Done must follow the last response, then the port stays quiet
task automatic check_run_end();
    int seen;
    if (responses_sent != expected_total) begin
        $display("Mismatch at %0t: done with %0d of %0d responses",
                 $time, responses_sent, expected_total);
        error_count++;
    end
    seen = accepted_count;
    repeat (20) @(negedge ap_clk);
    if ((accepted_count != seen) || (expected_q.size() != 0)) begin
        $display("Mismatch at %0t: %0d requests seen, %0d still expected",
                 $time, accepted_count, expected_q.size());
        error_count++;
    end
endtask

task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
        $display("[PASS] %s", name);
        tests_passed++;
    end else begin
        $display("[FAIL] %s", name);
        tests_failed++;
    end
endtask

initial begin : main
    int errors_before;
    int hold;
    int prog_cnt;
    void'($urandom(61));
    areset_cu_setup = 1'b1;
    descriptor      = '0;
    cu_flush        = 1'b0;
    response_valid  = 1'b0;
    request_ready   = 1'b1;
    random_ready    = 1'b0;
    withhold_last   = 1'b0;
    error_count     = 0;
    accepted_count  = 0;
    responses_sent  = 0;
    expected_total  = 0;
    tests_passed    = 0;
    tests_failed    = 0;

    apply_reset();
    errors_before = error_count;
    send_descriptor(make_setup_word(1'b0, $urandom_range(60, 1), 0));
    wait_for_done(10000);
    check_run_end();
    report_test("program_only", errors_before);

    apply_reset();
    errors_before = error_count;
    prog_cnt = $urandom_range(60, 1);
    send_descriptor(make_setup_word(1'b1, prog_cnt, $urandom_range(60, 1)));
    // Program run fully answered, so the FSM sits waiting on cu_flush
    wait_for_responses(prog_cnt, 10000);
    hold = $urandom_range(200, 20);
    repeat (hold) begin
        @(negedge ap_clk);
        if (done_out) begin
            $display("Mismatch at %0t: done_out high before cu_flush", $time);
            error_count++;
        end
    end
    cu_flush = 1'b1;
    wait_for_done(10000);
    check_run_end();
    report_test("program_then_flush", errors_before);

    // Count above the FIFO depth with a mostly stalled port
    apply_reset();
    errors_before = error_count;
    random_ready  = 1'b1;
    send_descriptor(make_setup_word(1'b0, $urandom_range(100, 33), 0));
    wait_for_done(10000);
    check_run_end();
    random_ready = 1'b0;
    report_test("back_pressure", errors_before);

    apply_reset();
    errors_before = error_count;
    withhold_last = 1'b1;
    send_descriptor(make_setup_word(1'b0, $urandom_range(60, 1), 0));
    wait_for_done(10000);
    check_run_end();
    withhold_last = 1'b0;
    report_test("response_gating", errors_before);

    apply_reset();
    errors_before = error_count;
    send_descriptor(make_setup_word(1'b0, 0, 0));
    wait_for_done(10000);
    check_run_end();
    report_test("zero_count", errors_before);

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (error_count == 0) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule : tb_cu_setup

/* verilog.f */
+incdir+testbench
hw/cu_setup_pkg.sv
hw/request_fifo.sv
hw/serial_read_engine.sv
hw/setup_sequencer.sv
hw/cu_setup_top.sv
testbench/tb_cu_setup.sv
